/* project.f */
+incdir+verif
rtl/cart_pkg.sv
rtl/download_gate.sv
rtl/cheat_code_assembler.sv
rtl/cart_header_parser.sv
rtl/region_select.sv
rtl/cart_loader_top.sv
verif/cart_loader_tb.sv

/* verif/cart_loader_model.svh */
// Reference model for the cartridge loader testbench
// Header region flags, region choice, quirk table and cheat code packing

`ifndef CART_LOADER_MODEL_SVH
`define CART_LOADER_MODEL_SVH

// {E, U, J} for one header character
function automatic logic [2:0] char_region(input logic [7:0] c);
	case (c)
		"J": return 3'b001;
		"U": return 3'b010;
		"E": return 3'b100;
		default: return 3'b000;
	endcase
endfunction

// b0 and b1 are the two bytes of the first region word, b2 the low byte of the second
function automatic logic [2:0] header_flags(input logic [7:0] b0, input logic [7:0] b1,
	input logic [7:0] b2);
	logic [3:0] hex_val;
	logic [2:0] flags;
	hex_val = 4'd0;
	flags   = char_region(b1) | char_region(b2);
	if (char_region(b0) != 3'b000)
		flags = flags | char_region(b0);
	else if (b0 >= "0" && b0 <= "9")
		hex_val = 4'(b0 - "0");
	else if (b0 >= "A" && b0 <= "F")
		hex_val = 4'(b0 - "A" + 10);
	return flags | {hex_val[3], hex_val[2], hex_val[0]};  // Bits 0, 2, 3 are J, U, E
endfunction

// First flagged region in the search order, else the head of the order
function automatic region_t pick_region(input prio_t prio, input logic [2:0] flags);
	logic [2:0][1:0] order;  // Entry 0 searched first
	case (prio)
		prio_us_eu_jp: order = {rgn_jp, rgn_eu, rgn_us};
		prio_eu_us_jp: order = {rgn_jp, rgn_us, rgn_eu};
		prio_us_jp_eu: order = {rgn_eu, rgn_jp, rgn_us};
		prio_jp_us_eu: order = {rgn_eu, rgn_us, rgn_jp};
	endcase
	for (int i = 0; i < 3; i++)
		if (flags[order[i]])
			return region_t'(order[i]);
	return region_t'(order[0]);
endfunction

// Known product codes, sram first, then eeprom, then svp
function automatic logic [63:0] table_id(input int n);
	case (n)
		0: return "T-081276";
		1: return "T-81406 ";
		2: return "T-081586";
		3: return "T-81576 ";
		4: return "MK-1215 ";
		5: return "G-4060  ";
		6: return "00001211";
		7: return "MK-1229 ";
		default: return "        ";
	endcase
endfunction

// {svp, eeprom, sram}
function automatic logic [2:0] expected_quirks(input logic [63:0] id);
	for (int n = 0; n < 8; n++)
		if (id == table_id(n))
			return (n < 4) ? 3'b001 : (n < 7) ? 3'b010 : 3'b100;
	return 3'b000;
endfunction

function automatic logic [code_w-1:0] pack_code(input logic [7:0][data_w-1:0] w);
	return {1'b1, w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]};
endfunction

`endif

/* verif/cart_loader_tb.sv */
// Testbench for the cartridge loader front end
// Clock, reset, loader stimulus and ROM acknowledge model
// Compare processes for ROM writes and cheat codes

`timescale 1ns/1ns

module cart_loader_tb import cart_pkg::*; ();

	localparam int wait_limit = 100;

	logic                  clk_sys;
	logic                  RESET;
	logic                  ioctl_download;
	logic                  ioctl_wr;
	logic [addr_w-1:0]     ioctl_addr;
	logic [data_w-1:0]     ioctl_data;
	logic [index_w-1:0]    ioctl_index;
	logic                  rom_wr_ack;
	auto_t                 auto_mode;
	prio_t                 region_prio;
	logic                  cart_download;
	logic                  code_download;
	logic                  rom_wr_req;
	logic [rom_addr_w-1:0] rom_addr;
	logic [data_w-1:0]     rom_wdata;
	logic                  ioctl_wait;
	logic [addr_w-1:0]     rom_size;
	logic [code_w-1:0]     cheat_code;
	logic                  code_valid;
	logic                  code_clear;
	logic                  hdr_j;
	logic                  hdr_u;
	logic                  hdr_e;
	logic                  hdr_ready;
	logic                  sram_quirk;
	logic                  eeprom_quirk;
	logic                  svp_quirk;
	region_t               region_req;
	logic                  region_set;

	logic [7:0]                   image [0:hdr_ready_addr + 1];  // Cartridge bytes
	logic [rom_addr_w+data_w-1:0] rom_expect [$];
	logic [rom_addr_w+data_w-1:0] rom_word;
	logic [code_w-1:0]            exp_code;
	logic                         mem_busy;
	logic                         req_last;
	int                           ack_delay;
	int                           toggle_cnt;
	int                           valid_cnt;
	int                           clear_cnt;

	`include "cart_loader_model.svh"

	cart_loader_top i_dut (.*);

	always #2 clk_sys = ~clk_sys;

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [code_w-1:0] got,
		input logic [code_w-1:0] exp);
		if (got !== exp) begin
			$display("Error %s: got 'h%0h, expected 'h%0h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		abort_run();
	endtask

	task automatic wait_loader_release();
		int n;
		n = 0;
		while (ioctl_wait !== 1'b0) begin
			@(negedge clk_sys);
			n++;
			if (n > wait_limit)
				report_timeout("ioctl_wait to fall");
		end
	endtask

	task automatic wait_header_ready();
		int n;
		n = 0;
		while (hdr_ready !== 1'b1) begin
			@(negedge clk_sys);
			n++;
			if (n > wait_limit)
				report_timeout("hdr_ready to rise");
		end
	endtask

	////////////////////////////////////////////////////////////
	// ROM acknowledge model and write compare
	always @(negedge clk_sys) begin
		if (RESET !== 1'b0) begin
			mem_busy = 1'b0;
			req_last = 1'b0;
		end else begin
			if (rom_wr_req !== req_last) begin
				toggle_cnt++;
				req_last = rom_wr_req;
			end
			if (!mem_busy && rom_wr_req !== rom_wr_ack) begin
				if (rom_expect.size() == 0) begin
					$display("ROM request seen with no cartridge write outstanding");
					abort_run();
				end else begin
					rom_word = rom_expect.pop_front();
					check_value("rom_addr", rom_addr, rom_word[rom_addr_w+data_w-1:data_w]);
					check_value("rom_wdata", rom_wdata, rom_word[data_w-1:0]);
					ack_delay = $urandom_range(6, 0);
					mem_busy  = 1'b1;
				end
			end
			if (mem_busy) begin
				if (ack_delay == 0) begin
					rom_wr_ack = rom_wr_req;  // Memory done
					mem_busy   = 1'b0;
				end else begin
					ack_delay--;
				end
			end
		end
	end

	// Cheat code compare on every load strobe
	always @(negedge clk_sys) begin
		if (RESET === 1'b0 && code_valid === 1'b1) begin
			valid_cnt++;
			check_value("cheat_code", cheat_code, exp_code);
		end
		if (RESET === 1'b0 && code_clear === 1'b1)
			clear_cnt++;
	end

	////////////////////////////////////////////////////////////
	// Cartridge image, product code and the three region bytes
	task automatic build_image(input logic [63:0] id, input logic [23:0] rgn);
		for (int a = 0; a <= hdr_ready_addr + 1; a++)
			image[a] = 8'((a * 37) ^ (a >> 4));
		for (int i = 0; i < 8; i++)
			image[id_first_addr + 1 + i] = id[63 - 8*i -: 8];
		image[hdr_region_addr]     = rgn[23:16];
		image[hdr_region_addr + 1] = rgn[15:8];
		image[hdr_region2_addr]    = rgn[7:0];
	endtask

	task automatic write_rom_word(input logic [addr_w-1:0] a);
		rom_expect.push_back({a[addr_w-1:1], image[a], image[a + 1]});  // Swapped for memory
		ioctl_addr = a;
		ioctl_data = {image[a + 1], image[a]};
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		check_value("ioctl_wait", ioctl_wait, 1'b1);
		wait_loader_release();
		check_value("rom_wr_ack", rom_wr_ack, rom_wr_req);
	endtask

	task automatic run_cart_download(input logic [index_w-1:0] index, input logic [63:0] id,
		input logic [23:0] rgn);
		int         toggles_at_start;
		logic [2:0] flags;
		build_image(id, rgn);
		flags            = header_flags(rgn[23:16], rgn[15:8], rgn[7:0]);
		toggles_at_start = toggle_cnt;
		ioctl_index      = index;
		ioctl_download   = 1'b1;
		@(negedge clk_sys);
		check_value("cart_download", cart_download, 1'b1);
		check_value("code_download", code_download, 1'b0);
		for (int a = 0; a <= hdr_ready_addr; a += 2)
			write_rom_word(a);
		wait_header_ready();
		@(negedge clk_sys);  // Region logic acts one cycle after hdr_ready
		check_value("hdr_flags", {hdr_e, hdr_u, hdr_j}, flags);
		check_value("quirks", {svp_quirk, eeprom_quirk, sram_quirk}, expected_quirks(id));
		case (auto_mode)
			auto_header: begin
				check_value("region_set", region_set, 1'b1);
				check_value("region_req", region_req, pick_region(region_prio, flags));
			end
			auto_ext: begin
				check_value("region_set", region_set, |index);
				check_value("region_req", region_req, index[7:6]);
			end
			default: check_value("region_set", region_set, 1'b0);
		endcase
		check_value("rom_wr_req toggles", toggle_cnt - toggles_at_start, hdr_ready_addr/2 + 1);
		check_value("pending ROM writes", rom_expect.size(), 0);
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		@(negedge clk_sys);
		check_value("cart_download", cart_download, 1'b0);
		check_value("rom_size", rom_size, hdr_ready_addr);  // Address held at the last word
		check_value("hdr_ready", hdr_ready, 1'b0);
		check_value("region_set", region_set, 1'b0);
	endtask

	task automatic write_code_word(input logic [addr_w-1:0] a, input logic [data_w-1:0] d);
		ioctl_addr = a;
		ioctl_data = d;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
	endtask

	task automatic load_cheat_code(input logic [addr_w-1:0] base, input int clears);
		logic [7:0][data_w-1:0] w;
		int                     valid_before;
		for (int i = 0; i < 8; i++)
			w[i] = 16'($urandom);
		exp_code     = pack_code(w);
		valid_before = valid_cnt;
		for (int i = 0; i < 8; i++)
			write_code_word(base + 2*i, w[i]);
		check_value("code_valid", code_valid, 1'b1);
		@(negedge clk_sys);
		@(negedge clk_sys);
		check_value("code_valid pulses", valid_cnt - valid_before, 1);
		check_value("code_clear pulses", clear_cnt, clears);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	initial begin
		void'($urandom(32'hf831));
		clk_sys        = 1'b0;
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		ioctl_index    = '0;
		rom_wr_ack     = 1'b0;
		auto_mode      = auto_header;
		region_prio    = prio_us_eu_jp;
		exp_code       = '0;
		toggle_cnt     = 0;
		valid_cnt      = 0;
		clear_cnt      = 0;
		repeat (4) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);
		check_value("reset outputs", {ioctl_wait, rom_wr_req, code_valid, code_clear, hdr_ready,
			region_set, sram_quirk, eeprom_quirk, svp_quirk}, 0);

		// Letters, hex digits and empty region field under every priority
		for (int p = 0; p < 4; p++) begin
			region_prio = prio_t'(p);
			run_cart_download(8'h00, "GM-00000", "JU ");
			run_cart_download(8'h00, "GM-00000", "  E");
			run_cart_download(8'h00, "GM-00000", "5  ");
			run_cart_download(8'h00, "GM-00000", "C J");
			run_cart_download(8'h00, "GM-00000", "   ");
		end

		for (int n = 0; n < 8; n++)
			run_cart_download(8'h00, table_id(n), "U  ");
		run_cart_download(8'h00, "T-00000 ", "U  ");  // Not in the table

		auto_mode = auto_ext;
		run_cart_download(8'h00, "GM-00000", "E  ");
		run_cart_download(8'h41, "GM-00000", "E  ");
		run_cart_download(8'h80, "GM-00000", "J  ");
		run_cart_download(8'hC2, "GM-00000", "U  ");
		auto_mode = auto_off;
		run_cart_download(8'h00, "GM-00000", "E  ");

		// Two cheat codes, only the first starts at address 0
		ioctl_index    = 8'hFF;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		check_value("code_download", code_download, 1'b1);
		check_value("cart_download", cart_download, 1'b0);
		load_cheat_code(25'd0, 1);
		load_cheat_code(25'd16, 1);
		ioctl_download = 1'b0;
		@(negedge clk_sys);
		check_value("code_download", code_download, 1'b0);
		check_value("rom_wr_req toggles", toggle_cnt, 34 * (hdr_ready_addr/2 + 1));

		$display("Result: PASSED");
		$finish;
	end

endmodule

/* rtl/cart_loader_top.sv */
// Cartridge download front end
// Download gate, cheat assembler, header parser and region select

`timescale 1ns/1ns

module cart_loader_top import cart_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  ioctl_download,
	input  logic                  ioctl_wr,
	input  logic [addr_w-1:0]     ioctl_addr,
	input  logic [data_w-1:0]     ioctl_data,
	input  logic [index_w-1:0]    ioctl_index,
	input  logic                  rom_wr_ack,
	input  auto_t                 auto_mode,
	input  prio_t                 region_prio,
	output logic                  cart_download,
	output logic                  code_download,
	output logic                  rom_wr_req,
	output logic [rom_addr_w-1:0] rom_addr,
	output logic [data_w-1:0]     rom_wdata,
	output logic                  ioctl_wait,
	output logic [addr_w-1:0]     rom_size,
	output logic [code_w-1:0]     cheat_code,
	output logic                  code_valid,
	output logic                  code_clear,
	output logic                  hdr_j,
	output logic                  hdr_u,
	output logic                  hdr_e,
	output logic                  hdr_ready,
	output logic                  sram_quirk,
	output logic                  eeprom_quirk,
	output logic                  svp_quirk,
	output region_t               region_req,
	output logic                  region_set
);

	////////////////////////////////////////////////////////////
	// Loader side and ROM writes
	download_gate i_download_gate (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ioctl_index    (ioctl_index),
		.rom_wr_ack     (rom_wr_ack),
		.cart_download  (cart_download),
		.code_download  (code_download),
		.rom_wr_req     (rom_wr_req),
		.rom_addr       (rom_addr),
		.rom_wdata      (rom_wdata),
		.ioctl_wait     (ioctl_wait),
		.rom_size       (rom_size)
	);

	cheat_code_assembler i_cheat_code_assembler (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.code_download (code_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_data    (ioctl_data),
		.cheat_code    (cheat_code),
		.code_valid    (code_valid),
		.code_clear    (code_clear)
	);

	cart_header_parser i_cart_header_parser (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.cart_download (cart_download),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_data    (ioctl_data),
		.hdr_j         (hdr_j),
		.hdr_u         (hdr_u),
		.hdr_e         (hdr_e),
		.hdr_ready     (hdr_ready),
		.sram_quirk    (sram_quirk),
		.eeprom_quirk  (eeprom_quirk),
		.svp_quirk     (svp_quirk)
	);

	// Consumer of the header result
	region_select i_region_select (
		.clk_sys     (clk_sys),
		.RESET       (RESET),
		.hdr_ready   (hdr_ready),
		.hdr_j       (hdr_j),
		.hdr_u       (hdr_u),
		.hdr_e       (hdr_e),
		.auto_mode   (auto_mode),
		.region_prio (region_prio),
		.ioctl_index (ioctl_index),
		.region_req  (region_req),
		.region_set  (region_set)
	);

endmodule

/* rtl/region_select.sv */
// Console region choice once the header is in
// Header priority, file extension and disabled modes

`timescale 1ns/1ns

module region_select import cart_pkg::*; (
	input  logic               clk_sys,
	input  logic               RESET,
	input  logic               hdr_ready,
	input  logic               hdr_j,
	input  logic               hdr_u,
	input  logic               hdr_e,
	input  auto_t              auto_mode,
	input  prio_t              region_prio,
	input  logic [index_w-1:0] ioctl_index,
	output region_t            region_req,
	output logic               region_set
);

	logic    rdy_q;
	region_t hdr_pick;

	// First flagged region in priority order, else the head of that order
	always_comb begin
		case (region_prio)
			prio_us_eu_jp:
				hdr_pick = hdr_u ? rgn_us : hdr_e ? rgn_eu : hdr_j ? rgn_jp : rgn_us;
			prio_eu_us_jp:
				hdr_pick = hdr_e ? rgn_eu : hdr_u ? rgn_us : hdr_j ? rgn_jp : rgn_eu;
			prio_us_jp_eu:
				hdr_pick = hdr_u ? rgn_us : hdr_j ? rgn_jp : hdr_e ? rgn_eu : rgn_us;
			prio_jp_us_eu:
				hdr_pick = hdr_j ? rgn_jp : hdr_u ? rgn_us : hdr_e ? rgn_eu : rgn_jp;
			default:
				hdr_pick = rgn_us;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rdy_q      <= 1'b0;
			region_set <= 1'b0;
			region_req <= rgn_jp;
		end else begin
			rdy_q <= hdr_ready;
			if (hdr_ready && !rdy_q) begin
				case (auto_mode)
					auto_header: begin
						region_req <= hdr_pick;
						region_set <= 1'b1;
					end
					auto_ext: begin
						region_req <= region_t'(ioctl_index[7:6]);  // Extension code from loader
						region_set <= |ioctl_index;
					end
					auto_off: ;
					default: ;
				endcase
			end
			if (rdy_q && !hdr_ready)
				region_set <= 1'b0;  // Download over
		end
	end

	// Region only forced while the header is complete
	a_set_after_ready : assert property (@(posedge clk_sys) disable iff (RESET)
		$rose(region_set) |-> hdr_ready);

endmodule

/* rtl/cart_header_parser.sv */
// Region letters from the cartridge header
// Header-ready flag for the region logic
// Product code capture and quirk table lookup

`timescale 1ns/1ns

module cart_header_parser import cart_pkg::*; (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              cart_download,
	input  logic              ioctl_wr,
	input  logic [addr_w-1:0] ioctl_addr,
	input  logic [data_w-1:0] ioctl_data,
	output logic              hdr_j,
	output logic              hdr_u,
	output logic              hdr_e,
	output logic              hdr_ready,
	output logic              sram_quirk,
	output logic              eeprom_quirk,
	output logic              svp_quirk
);

	logic        dl_q;
	logic        dl_rise;
	logic        dl_fall;
	logic        hdr_wr;
	logic [2:0]  rgn_flags;  // {E, U, J}
	logic [7:0]  lo_chr;
	logic [7:0]  hi_chr;
	logic [3:0]  hex_af;
	logic [63:0] cart_id;

	// Flag mask for a single region letter
	function automatic logic [2:0] letter_mask(input logic [7:0] chr);
		return {chr == "E", chr == "U", chr == "J"};
	endfunction

	assign dl_rise = cart_download & ~dl_q;
	assign dl_fall = dl_q & ~cart_download;
	assign hdr_wr  = cart_download & ioctl_wr;
	assign lo_chr  = ioctl_data[7:0];
	assign hi_chr  = ioctl_data[15:8];
	assign hex_af  = lo_chr[3:0] - 4'd7;  // 'A'..'F' to 10..15

	assign {hdr_e, hdr_u, hdr_j} = rgn_flags;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_q      <= 1'b0;
			rgn_flags <= '0;
			hdr_ready <= 1'b0;
		end else begin
			dl_q <= cart_download;
			if (dl_rise) rgn_flags <= '0;
			if (dl_fall) hdr_ready <= 1'b0;
			if (hdr_wr && ioctl_addr == hdr_region_addr) begin
				// Low byte is a letter or a hex region mask
				if (|letter_mask(lo_chr))
					rgn_flags <= rgn_flags | letter_mask(lo_chr) | letter_mask(hi_chr);
				else if (lo_chr >= "0" && lo_chr <= "9")
					rgn_flags <= {lo_chr[3], lo_chr[2], lo_chr[0]} | letter_mask(hi_chr);
				else if (lo_chr >= "A" && lo_chr <= "F")
					rgn_flags <= {hex_af[3], hex_af[2], hex_af[0]} | letter_mask(hi_chr);
				else
					rgn_flags <= rgn_flags | letter_mask(hi_chr);
			end
			if (hdr_wr && ioctl_addr == hdr_region2_addr)
				rgn_flags <= rgn_flags | letter_mask(lo_chr);
			if (hdr_wr && ioctl_addr == hdr_ready_addr)
				hdr_ready <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Product code, eight characters
	always_ff @(posedge clk_sys) begin
		if (hdr_wr) begin
			case (ioctl_addr)
				id_first_addr:      cart_id[63:56] <= hi_chr;
				id_first_addr + 2:  cart_id[55:40] <= {lo_chr, hi_chr};
				id_first_addr + 4:  cart_id[39:24] <= {lo_chr, hi_chr};
				id_first_addr + 6:  cart_id[23:8]  <= {lo_chr, hi_chr};
				id_last_addr:       cart_id[7:0]   <= lo_chr;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			sram_quirk   <= 1'b0;
			eeprom_quirk <= 1'b0;
			svp_quirk    <= 1'b0;
		end else if (dl_rise) begin
			sram_quirk   <= 1'b0;
			eeprom_quirk <= 1'b0;
			svp_quirk    <= 1'b0;
		end else if (hdr_wr && ioctl_addr == id_check_addr) begin
			case (cart_id)
				"T-081276", "T-81406 ", "T-081586", "T-81576 ":
					sram_quirk <= 1'b1;    // Battery RAM mapped despite header
				"MK-1215 ", "G-4060  ", "00001211":
					eeprom_quirk <= 1'b1;  // Serial EEPROM saves
				"MK-1229 ":
					svp_quirk <= 1'b1;
				default: ;
			endcase
		end
	end

endmodule

/* rtl/cheat_code_assembler.sv */
// Cheat code assembly from 16-bit loader words
// Load strobe and clear pulse for the cheat engine

`timescale 1ns/1ns

module cheat_code_assembler import cart_pkg::*; (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              code_download,
	input  logic              ioctl_wr,
	input  logic [addr_w-1:0] ioctl_addr,
	input  logic [data_w-1:0] ioctl_data,
	output logic [code_w-1:0] cheat_code,
	output logic              code_valid,
	output logic              code_clear
);

	logic                    code_wr;
	logic                    code_stb;
	logic [code_stb_bit-1:0] code_body;

	assign code_wr    = code_download & ioctl_wr;
	assign cheat_code = {code_stb, code_body};
	assign code_valid = code_stb;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_stb   <= 1'b0;
			code_clear <= 1'b0;
		end else begin
			code_stb   <= code_wr && (ioctl_addr[3:0] == 4'd14);  // Last word of a code
			code_clear <= code_wr && (ioctl_addr == '0);
		end
	end

	////////////////////////////////////////////////////////////
	// Word placement, low half of each field first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  code_body[code_flags_lsb +: data_w]          <= ioctl_data;
				4'd2:  code_body[code_flags_lsb + data_w +: data_w] <= ioctl_data;
				4'd4:  code_body[code_addr_lsb +: data_w]           <= ioctl_data;
				4'd6:  code_body[code_addr_lsb + data_w +: data_w]  <= ioctl_data;
				4'd8:  code_body[code_cmp_lsb +: data_w]            <= ioctl_data;
				4'd10: code_body[code_cmp_lsb + data_w +: data_w]   <= ioctl_data;
				4'd12: code_body[code_rep_lsb +: data_w]            <= ioctl_data;
				4'd14: code_body[code_rep_lsb + data_w +: data_w]   <= ioctl_data;
				default: ;
			endcase
		end
	end

	// Engine loads once per code
	a_valid_pulse : assert property (@(posedge clk_sys) disable iff (RESET)
		code_valid |=> !code_valid);

endmodule

/* rtl/download_gate.sv */
// Download type decode from the loader index
// ROM write request with toggle handshake and loader wait
// ROM size capture at the end of a cartridge download

`timescale 1ns/1ns

module download_gate import cart_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  RESET,
	input  logic                  ioctl_download,
	input  logic                  ioctl_wr,
	input  logic [addr_w-1:0]     ioctl_addr,
	input  logic [data_w-1:0]     ioctl_data,
	input  logic [index_w-1:0]    ioctl_index,
	input  logic                  rom_wr_ack,
	output logic                  cart_download,
	output logic                  code_download,
	output logic                  rom_wr_req,
	output logic [rom_addr_w-1:0] rom_addr,
	output logic [data_w-1:0]     rom_wdata,
	output logic                  ioctl_wait,
	output logic [addr_w-1:0]     rom_size
);

	logic code_sel;
	logic dl_q;  // cart_download one cycle late

	// All ones index selects the cheat file
	assign code_sel      = &ioctl_index;
	assign cart_download = ioctl_download & ~code_sel;
	assign code_download = ioctl_download & code_sel;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_wr_req <= 1'b0;
			ioctl_wait <= 1'b0;
			dl_q       <= 1'b0;
		end else begin
			dl_q <= cart_download;
			if (cart_download && ioctl_wr) begin
				rom_wr_req <= ~rom_wr_req;  // New request pending
				ioctl_wait <= 1'b1;
			end else if (ioctl_wait && (rom_wr_req == rom_wr_ack)) begin
				ioctl_wait <= 1'b0;         // Memory caught up
			end
		end
	end

	// Word held for memory, bytes swapped
	always_ff @(posedge clk_sys) begin
		if (cart_download && ioctl_wr) begin
			rom_addr  <= ioctl_addr[addr_w-1:1];
			rom_wdata <= {ioctl_data[7:0], ioctl_data[15:8]};
		end
		if (dl_q && !cart_download)
			rom_size <= ioctl_addr;  // Last address of the image
	end

	// A new request only starts once the previous one has drained
	a_req_idle : assert property (@(posedge clk_sys) disable iff (RESET)
		$changed(rom_wr_req) |-> !$past(ioctl_wait));

endmodule

/* rtl/cart_pkg.sv */
// Shared widths and header addresses for the cartridge loader
// Cheat code word layout
// Region, priority and auto mode encodings

package cart_pkg;

	////////////////////////////////////////////////////////////
	// Loader and memory widths
	localparam int addr_w     = 25;  // Loader byte address
	localparam int data_w     = 16;
	localparam int rom_addr_w = 24;  // ROM word address
	localparam int index_w    = 8;
	localparam int code_w     = 129;

	////////////////////////////////////////////////////////////
	// Cartridge header locations
	localparam logic [addr_w-1:0] hdr_region_addr  = 25'h1F0;
	localparam logic [addr_w-1:0] hdr_region2_addr = 25'h1F2;
	localparam logic [addr_w-1:0] hdr_ready_addr   = 25'h200;  // Header fully received

	// Product code words and the lookup point just past them
	localparam logic [addr_w-1:0] id_first_addr = 25'h182;
	localparam logic [addr_w-1:0] id_last_addr  = 25'h18A;
	localparam logic [addr_w-1:0] id_check_addr = 25'h18C;

	////////////////////////////////////////////////////////////
	// Cheat code layout, strobe bit on top
	localparam int code_stb_bit   = 128;
	localparam int code_flags_lsb = 96;
	localparam int code_addr_lsb  = 64;
	localparam int code_cmp_lsb   = 32;
	localparam int code_rep_lsb   = 0;

	typedef enum logic [1:0] {
		rgn_jp = 2'd0,
		rgn_us = 2'd1,
		rgn_eu = 2'd2
	} region_t;

	// Search order when header flags are checked
	typedef enum logic [1:0] {
		prio_us_eu_jp = 2'd0,
		prio_eu_us_jp = 2'd1,
		prio_us_jp_eu = 2'd2,
		prio_jp_us_eu = 2'd3
	} prio_t;

	typedef enum logic [1:0] {
		auto_header = 2'd0,
		auto_ext    = 2'd1,  // Region from file extension index
		auto_off    = 2'd2
	} auto_t;

endpackage
